//--- design/clkgen_macros.svh
// Clock generator parameters

`ifndef CLKGEN_MACROS_SVH
`define CLKGEN_MACROS_SVH

// Generated clock domains
`define CLKGEN_NUM_DOMAINS 3

// Configuration bus widths
`define CLKGEN_DATA_W 16
`define CLKGEN_ADDR_W 3

// Flops in each domain reset synchroniser
`define CLKGEN_SYNC_STAGES 2

// Register map
`define CLKGEN_GATE_ADDR 3  // Gate bits, one per domain
`define CLKGEN_DIV_RESET 1  // Divider value after reset

`endif

//--- design/clkgen_pkg.sv
// Clock generator types
`default_nettype none

`include "clkgen_macros.svh"

package clkgen_pkg;

  // Bus vectors
  typedef logic [`CLKGEN_ADDR_W-1:0] cfg_addr_t;
  typedef logic [`CLKGEN_DATA_W-1:0] cfg_data_t;

  // Half-period length in reference clock cycles
  typedef logic [`CLKGEN_DATA_W-1:0] div_value_t;

  // One bit per generated domain
  typedef logic [`CLKGEN_NUM_DOMAINS-1:0] dom_vec_t;

  // Master to responder payload, held stable while req is high
  typedef struct packed {
    cfg_addr_t addr;   // Register address
    cfg_data_t wdata;  // Write data
    logic      we;     // High for a write
  } cfg_req_t;

  // Responder to master payload, valid while ack is high
  typedef struct packed {
    cfg_data_t rdata;
  } cfg_rsp_t;

  // Arbiter FSM
  typedef enum logic [1:0] {
    IDLE,     // Sampling both masters
    BUSY,     // Request forwarded, waiting for the master to drop req
    RELEASE   // Waiting for the slave ack to fall
  } arb_state_t;

endpackage

`default_nettype wire

//--- design/cfg_arbiter.sv
// Configuration bus arbiter
`timescale 1ns/10ps
`default_nettype none

module cfg_arbiter (
  input  wire logic                 clk,
  input  wire logic                 rst_n_i,

  // Host master
  input  wire logic                 host_req_i,
  input  wire clkgen_pkg::cfg_req_t host_cfg_i,
  output logic                      host_ack_o,
  output clkgen_pkg::cfg_rsp_t      host_rsp_o,

  // Debug master
  input  wire logic                 dbg_req_i,
  input  wire clkgen_pkg::cfg_req_t dbg_cfg_i,
  output logic                      dbg_ack_o,
  output clkgen_pkg::cfg_rsp_t      dbg_rsp_o,

  // Register block side
  output logic                      slv_req_o,
  output clkgen_pkg::cfg_req_t      slv_cfg_o,
  input  wire logic                 slv_ack_i,
  input  wire clkgen_pkg::cfg_rsp_t slv_rsp_i
);

  import clkgen_pkg::*;

  arb_state_t state_q;
  arb_state_t state_d;
  logic       last_dbg_q;  // Debug served last; also selects the current winner
  logic       pick_dbg;
  logic       win_req;
  logic       granted;
  cfg_req_t   slv_cfg_q;

  // Round robin: debug wins a tie unless it was served last
  assign pick_dbg = dbg_req_i & (~host_req_i | ~last_dbg_q);

  // Request of the master currently holding the grant
  assign win_req = last_dbg_q ? dbg_req_i : host_req_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (host_req_i | dbg_req_i) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        // Phase 3 done, master has seen ack and dropped req
        if (slv_ack_i & ~win_req) begin
          state_d = RELEASE;
        end
      end
      RELEASE: begin
        if (!slv_ack_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      last_dbg_q <= 1'b0;  // Host counts as last served, debug goes first
    end else begin
      state_q <= state_d;
      if ((state_q == IDLE) && (host_req_i | dbg_req_i)) begin
        last_dbg_q <= pick_dbg;
      end
    end
  end

  // Winner payload captured on the grant edge
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      slv_cfg_q <= pick_dbg ? dbg_cfg_i : host_cfg_i;
    end
  end

  assign granted = (state_q != IDLE);

  assign slv_req_o = (state_q == BUSY) & win_req;
  assign slv_cfg_o = slv_cfg_q;

  // Ack and read data go back to the winner only
  assign host_ack_o = granted & ~last_dbg_q & slv_ack_i;
  assign dbg_ack_o  = granted &  last_dbg_q & slv_ack_i;
  assign host_rsp_o = (granted & ~last_dbg_q) ? slv_rsp_i : '0;
  assign dbg_rsp_o  = (granted &  last_dbg_q) ? slv_rsp_i : '0;

endmodule

`default_nettype wire

//--- design/clk_cfg_regs.sv
// Clock configuration registers
`timescale 1ns/10ps
`default_nettype none

`include "clkgen_macros.svh"

module clk_cfg_regs (
  input  wire logic                 clk,
  input  wire logic                 rst_n_i,

  // Four-phase configuration port
  input  wire logic                 req_i,
  input  wire clkgen_pkg::cfg_req_t cfg_i,
  output logic                      ack_o,
  output clkgen_pkg::cfg_rsp_t      rsp_o,

  // Domain controls
  output clkgen_pkg::div_value_t [`CLKGEN_NUM_DOMAINS-1:0] div_o,
  output clkgen_pkg::dom_vec_t                             gate_o
);

  import clkgen_pkg::*;

  logic                                   ack_q;
  logic                                   req_new;
  logic                                   wr_en;
  div_value_t [`CLKGEN_NUM_DOMAINS-1:0]   div_q;
  div_value_t [`CLKGEN_NUM_DOMAINS-1:0]   div_d;
  dom_vec_t                               gate_q;
  dom_vec_t                               gate_d;
  cfg_data_t                              rdata_q;
  cfg_data_t                              rdata_d;

  // Req high with ack still low marks the start of a handshake
  assign req_new = req_i & ~ack_q;
  assign wr_en   = req_new & cfg_i.we;  // Once per handshake

  // Next register state and the data returned to the master
  always_comb begin
    div_d   = div_q;
    gate_d  = gate_q;
    rdata_d = '0;  // Unmapped addresses read zero

    for (int k = 0; k < `CLKGEN_NUM_DOMAINS; k++) begin
      if (cfg_i.addr == cfg_addr_t'(k)) begin
        if (wr_en) begin
          // A zero divider is stored as one
          div_d[k] = (cfg_i.wdata == '0) ? div_value_t'(1) : cfg_i.wdata;
        end
        rdata_d = div_d[k];
      end
    end

    if (cfg_i.addr == cfg_addr_t'(`CLKGEN_GATE_ADDR)) begin
      if (wr_en) begin
        gate_d = cfg_i.wdata[`CLKGEN_NUM_DOMAINS-1:0];
      end
      rdata_d = cfg_data_t'(gate_d);
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q  <= 1'b0;
      div_q  <= {`CLKGEN_NUM_DOMAINS{div_value_t'(`CLKGEN_DIV_RESET)}};
      gate_q <= '0;
    end else begin
      ack_q  <= req_i;  // Follows req one cycle late
      div_q  <= div_d;
      gate_q <= gate_d;
    end
  end

  // Read data settles on the same edge as ack rises
  always_ff @(posedge clk) begin
    if (req_new) begin
      rdata_q <= rdata_d;
    end
  end

  assign ack_o       = ack_q;
  assign rsp_o.rdata = rdata_q;
  assign div_o       = div_q;
  assign gate_o      = gate_q;

endmodule

`default_nettype wire

//--- design/clk_domain_gen.sv
// Clock domain divider and reset
`timescale 1ns/10ps
`default_nettype none

`include "clkgen_macros.svh"

module clk_domain_gen #(
  parameter bit USE_DBG_RST = 1'b1  // Debug reset also resets this domain
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n_i,
  input  wire logic                   dbg_rst_i,

  input  wire clkgen_pkg::div_value_t div_i,   // Half period in clk cycles
  input  wire logic                   gate_i,  // High stops the clock low

  output logic                        clk_o,
  output logic                        rstn_o
);

  import clkgen_pkg::*;

  logic                            clk_q;
  div_value_t                      cnt_q;    // Cycles left in the phase, minus one
  div_value_t                      div_q;    // Half period of the running cycle
  div_value_t                      div_new;
  logic                            phase_end;
  logic                            rst_src_n;
  logic [`CLKGEN_SYNC_STAGES-1:0]  sync_q;

  // Zero behaves as one
  assign div_new = (div_i == '0) ? div_value_t'(1) : div_i;

  assign phase_end = (cnt_q == '0);

  // Half-period counter
  // Reset leaves the counter at the end of a low phase, so the clock
  // rises on the first edge after reset release
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clk_q <= 1'b0;
      cnt_q <= '0;
    end else if (!phase_end) begin
      cnt_q <= cnt_q - 1'b1;
    end else if (clk_q) begin
      // High phase done, low phase of the same length
      clk_q <= 1'b0;
      cnt_q <= div_q - 1'b1;
    end else if (!gate_i) begin
      clk_q <= 1'b1;         // Low phase done, start a new period
      cnt_q <= div_new - 1'b1;
    end
    // Gated: stay low at the end of the low phase
  end

  // New divider value only at a period start
  always_ff @(posedge clk) begin
    if (phase_end && !clk_q && !gate_i) begin
      div_q <= div_new;
    end
  end

  assign clk_o = clk_q;

  // Reset sources
  assign rst_src_n = rst_n_i & ~(USE_DBG_RST & dbg_rst_i);

  // Asynchronous assert, release on the generated clock
  always_ff @(posedge clk_q or negedge rst_src_n) begin
    if (!rst_src_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`CLKGEN_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign rstn_o = sync_q[`CLKGEN_SYNC_STAGES-1];  // Last stage

endmodule

`default_nettype wire

//--- design/clkgen_top.sv
// Clock and reset generator
`timescale 1ns/10ps
`default_nettype none

`include "clkgen_macros.svh"

module clkgen_top (
  input  wire logic                 clk,
  input  wire logic                 rst_n_i,
  input  wire logic                 dbg_rst_i,

  // Host configuration port
  input  wire logic                 host_req_i,
  input  wire clkgen_pkg::cfg_req_t host_cfg_i,
  output logic                      host_ack_o,
  output clkgen_pkg::cfg_rsp_t      host_rsp_o,

  // Debug configuration port
  input  wire logic                 dbg_req_i,
  input  wire clkgen_pkg::cfg_req_t dbg_cfg_i,
  output logic                      dbg_ack_o,
  output clkgen_pkg::cfg_rsp_t      dbg_rsp_o,

  // Generated clocks and resets
  output clkgen_pkg::dom_vec_t      dom_clk_o,
  output clkgen_pkg::dom_vec_t      dom_rstn_o,
  output logic                      glob_rstn_o
);

  import clkgen_pkg::*;

  logic                                  slv_req;
  cfg_req_t                              slv_cfg;
  logic                                  slv_ack;
  cfg_rsp_t                              slv_rsp;
  div_value_t [`CLKGEN_NUM_DOMAINS-1:0]  div;
  dom_vec_t                              gate;

  cfg_arbiter u_arbiter (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .host_req_i (host_req_i),
    .host_cfg_i (host_cfg_i),
    .host_ack_o (host_ack_o),
    .host_rsp_o (host_rsp_o),
    .dbg_req_i  (dbg_req_i),
    .dbg_cfg_i  (dbg_cfg_i),
    .dbg_ack_o  (dbg_ack_o),
    .dbg_rsp_o  (dbg_rsp_o),
    .slv_req_o  (slv_req),
    .slv_cfg_o  (slv_cfg),
    .slv_ack_i  (slv_ack),
    .slv_rsp_i  (slv_rsp)
  );

  clk_cfg_regs u_regs (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (slv_req),
    .cfg_i   (slv_cfg),
    .ack_o   (slv_ack),
    .rsp_o   (slv_rsp),
    .div_o   (div),
    .gate_o  (gate)
  );

  for (genvar k = 0; k < `CLKGEN_NUM_DOMAINS; k++) begin : g_dom
    clk_domain_gen #(
      .USE_DBG_RST (1'b1)
    ) u_dom (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .dbg_rst_i (dbg_rst_i),
      .div_i     (div[k]),
      .gate_i    (gate[k]),
      .clk_o     (dom_clk_o[k]),
      .rstn_o    (dom_rstn_o[k])
    );
  end

  // Global reset runs on a copy of domain 0's clock, debug reset ignored
  clk_domain_gen #(
    .USE_DBG_RST (1'b0)
  ) u_glob (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .dbg_rst_i (dbg_rst_i),
    .div_i     (div[0]),
    .gate_i    (gate[0]),
    .clk_o     (),
    .rstn_o    (glob_rstn_o)
  );

endmodule

`default_nettype wire

//--- bench/clkgen_sva.sv
// Handshake and reset assertions
`timescale 1ns/10ps
`default_nettype none

module clkgen_sva #(
  parameter bit HAS_BUS = 1'b1  // Target answers a four-phase port
) (
  input wire logic                 clk,
  input wire logic                 rst_n_i,
  input wire logic                 req_i,
  input wire logic                 ack_i,
  input wire clkgen_pkg::cfg_req_t cfg_i,
  input wire logic                 rst_out_i  // Must be low in reset
);

  import clkgen_pkg::*;

  if (HAS_BUS) begin : g_bus
    // Ack only follows a request
    assert property (@(posedge clk) disable iff (!rst_n_i) $rose(ack_i) |-> $past(req_i))
      else $error("Ack rose without a request");

    // Payload held over the cycle in which the request is answered
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     (req_i && !ack_i) |=> $stable(cfg_i))
      else $error("Payload changed while waiting for ack");
  end

  assert property (@(posedge clk) !rst_n_i |-> !rst_out_i)
    else $error("Output not held low during reset");

endmodule

bind clk_cfg_regs clkgen_sva regs_sva (
  .clk       (clk),
  .rst_n_i   (rst_n_i),
  .req_i     (req_i),
  .ack_i     (ack_o),
  .cfg_i     (cfg_i),
  .rst_out_i (ack_o)
);

bind clk_domain_gen clkgen_sva #(
  .HAS_BUS (1'b0)
) dom_sva (
  .clk       (clk),
  .rst_n_i   (rst_n_i),
  .req_i     (1'b0),
  .ack_i     (1'b0),
  .cfg_i     (clkgen_pkg::cfg_req_t'(0)),
  .rst_out_i (rstn_o)
);

`default_nettype wire

//--- bench/clkgen_tb.sv
// Clock generator testbench
`timescale 1ns/10ps
`default_nettype none

`include "clkgen_macros.svh"

module clkgen_tb;

  import clkgen_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_RAND   = 40;
  localparam int NUM_ACC    = 64;   // Upper bound on bus accesses
  localparam int NUM_MEAS   = 10;   // Period measurements
  localparam int MAX_HALF   = 16;   // Largest divider used anywhere
  localparam int WDOG_CYCLES = 1000 + NUM_ACC * 200 + NUM_MEAS * 40 * 2 * MAX_HALF;

  logic       clk;
  logic       rst_n;
  logic       dbg_rst;
  logic       host_req;
  logic       dbg_req;
  cfg_req_t   host_cfg;
  cfg_req_t   dbg_cfg;
  logic       host_ack;
  logic       dbg_ack;
  cfg_rsp_t   host_rsp;
  cfg_rsp_t   dbg_rsp;
  dom_vec_t   dom_clk;
  dom_vec_t   dom_rstn;
  logic       glob_rstn;

  integer     seed = 32817;
  int         err_cnt = 0;

  // Register map model with reset values
  cfg_data_t  div_m [0:`CLKGEN_NUM_DOMAINS-1] = '{16'd1, 16'd1, 16'd1};
  dom_vec_t   gate_m = '0;

  clkgen_top dut_i (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .dbg_rst_i   (dbg_rst),
    .host_req_i  (host_req),
    .host_cfg_i  (host_cfg),
    .host_ack_o  (host_ack),
    .host_rsp_o  (host_rsp),
    .dbg_req_i   (dbg_req),
    .dbg_cfg_i   (dbg_cfg),
    .dbg_ack_o   (dbg_ack),
    .dbg_rsp_o   (dbg_rsp),
    .dom_clk_o   (dom_clk),
    .dom_rstn_o  (dom_rstn),
    .glob_rstn_o (glob_rstn)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Expected read data for an address
  function automatic cfg_data_t ref_read(cfg_addr_t addr);
    if (addr < 3'd3) begin
      return div_m[addr];
    end else if (addr == 3'd3) begin
      return cfg_data_t'(gate_m);
    end
    return '0;  // Unmapped
  endfunction

  function automatic void ref_write(cfg_addr_t addr, cfg_data_t data);
    if (addr < 3'd3) begin
      div_m[addr] = (data == '0) ? 16'd1 : data;
    end else if (addr == 3'd3) begin
      gate_m = data[`CLKGEN_NUM_DOMAINS-1:0];
    end
  endfunction

  task automatic report_failure(input string what);
    err_cnt++;
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_data(input string name, input cfg_data_t got, input cfg_data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_period(input string name, input div_value_t half, input int cycles);
    int exp;
    exp = (half == '0) ? 2 : 2 * int'(half);
    if (cycles != exp) begin
      report_failure($sformatf("CHECK FAILED %s: got 0x%h cycles, expected 0x%h",
                               name, cycles, exp));
    end
  endtask

  task automatic check_dom(input string name, input dom_vec_t got, input dom_vec_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Four-phase transfer driven and sampled on the falling edge
  task automatic bus_access(input bit use_dbg, input cfg_req_t req,
                            output cfg_data_t rdata, output time t_ack);
    @(negedge clk);
    if (use_dbg) begin
      dbg_cfg = req;
      dbg_req = 1'b1;
    end else begin
      host_cfg = req;
      host_req = 1'b1;
    end
    do @(negedge clk); while (!(use_dbg ? dbg_ack : host_ack));
    rdata = use_dbg ? dbg_rsp.rdata : host_rsp.rdata;
    t_ack = $time;
    if (use_dbg) dbg_req = 1'b0;
    else host_req = 1'b0;
    do @(negedge clk); while (use_dbg ? dbg_ack : host_ack);  // Phase 4
  endtask

  task automatic host_access(input cfg_req_t req, output cfg_data_t rdata, output time t_ack);
    bus_access(1'b0, req, rdata, t_ack);
  endtask

  task automatic dbg_access(input cfg_req_t req, output cfg_data_t rdata, output time t_ack);
    bus_access(1'b1, req, rdata, t_ack);
  endtask

  task automatic checked_access(input bit use_dbg, input cfg_addr_t addr, input bit we,
                                input cfg_data_t data);
    cfg_req_t  req;
    cfg_data_t rdata;
    time       t_ack;
    req.addr  = addr;
    req.wdata = data;
    req.we    = we;
    if (use_dbg) dbg_access(req, rdata, t_ack);
    else host_access(req, rdata, t_ack);
    if (we) ref_write(addr, data);
    check_data(use_dbg ? "dbg_rsp_o.rdata" : "host_rsp_o.rdata", rdata, ref_read(addr));
  endtask

  // Both ports write distinct addresses at once
  task automatic pair_access(input cfg_addr_t ha, input cfg_data_t hd,
                             input cfg_addr_t da, input cfg_data_t dd, input bit dbg_first);
    cfg_req_t  hreq;
    cfg_req_t  dreq;
    cfg_data_t hdata;
    cfg_data_t ddata;
    time       t_host;
    time       t_dbg;
    hreq = '{addr: ha, wdata: hd, we: 1'b1};
    dreq = '{addr: da, wdata: dd, we: 1'b1};
    fork
      host_access(hreq, hdata, t_host);
      dbg_access(dreq, ddata, t_dbg);
    join
    ref_write(ha, hd);
    ref_write(da, dd);
    check_data("host_rsp_o.rdata", hdata, ref_read(ha));
    check_data("dbg_rsp_o.rdata", ddata, ref_read(da));
    if (dbg_first != (t_dbg < t_host)) begin
      report_failure($sformatf("Arbitration served the %s port first",
                               (t_dbg < t_host) ? "debug" : "host"));
    end
  endtask

  // Clock cycles of one full period after one full period has passed
  task automatic measure_period(input int k, output int cycles);
    bit prev;
    int rises;
    prev   = dom_clk[k];
    rises  = 0;
    cycles = 0;
    while (rises < 3) begin
      @(negedge clk);
      if (rises >= 2) cycles++;
      if (dom_clk[k] && !prev) rises++;
      prev = dom_clk[k];
    end
  endtask

  // Reset must release on exactly the second domain clock edge
  task automatic release_check(input int k, input bit with_glob);
    bit       prev;
    int       rises;
    dom_vec_t mask;
    mask  = dom_vec_t'(1 << k);
    prev  = dom_clk[k];
    rises = 0;
    while (rises < 2) begin
      @(negedge clk);
      if (dom_clk[k] && !prev) begin
        rises++;
        check_dom("dom_rstn_o", dom_rstn & mask, (rises == 2) ? mask : '0);
        if (with_glob) begin
          check_dom("glob_rstn_o", dom_vec_t'(glob_rstn), dom_vec_t'(rises == 2));
        end
      end
      prev = dom_clk[k];
    end
  endtask

  // Watchdog
  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Watchdog timeout, the test sequence did not complete in time");
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    cfg_addr_t a;
    cfg_data_t d;
    bit        we;
    bit        use_dbg;
    int        cycles;
    dom_vec_t  toggled;
    dom_vec_t  prev_clk;
    cfg_data_t vals [0:2];

    vals     = '{16'd0, 16'd5, 16'd12};
    rst_n    = 1'b0;
    dbg_rst  = 1'b0;
    host_req = 1'b0;
    dbg_req  = 1'b0;
    host_cfg = '0;
    dbg_cfg  = '0;

    // Reset
    repeat (10) @(negedge clk);
    check_dom("dom_rstn_o", dom_rstn, '0);
    check_dom("glob_rstn_o", dom_vec_t'(glob_rstn), '0);
    check_dom("dom_clk_o", dom_clk, '0);
    rst_n = 1'b1;
    fork
      release_check(0, 1'b1);
      release_check(1, 1'b0);
      release_check(2, 1'b0);
    join

    // Arbitration with debug first after reset and then alternation
    pair_access(3'd2, 16'd3, 3'd1, 16'd5, 1'b1);
    checked_access(1'b1, 3'd0, 1'b1, 16'd2);
    pair_access(3'd2, 16'd6, 3'd1, 16'd4, 1'b0);

    // Random register traffic
    for (int i = 0; i < NUM_RAND; i++) begin
      use_dbg = 1'($random(seed));
      a       = cfg_addr_t'($random(seed));
      we      = 1'($random(seed));
      d       = cfg_data_t'($random(seed));
      if (a < 3'd3) d = d & 16'h000F;  // Keep periods short
      checked_access(use_dbg, a, we, d);
    end

    // Dividers including zero
    checked_access(1'b0, 3'd3, 1'b1, 16'h0000);
    for (int i = 0; i < 3; i++) begin
      for (int k = 0; k < 3; k++) begin
        checked_access(1'b0, cfg_addr_t'(k), 1'b1, vals[(k + i) % 3]);
        measure_period(k, cycles);
        check_period($sformatf("dom_clk_o[%0d] period", k), vals[(k + i) % 3], cycles);
      end
    end

    // Gating domain 1
    checked_access(1'b1, 3'd3, 1'b1, 16'h0002);
    repeat (2 * MAX_HALF + 4) @(negedge clk);
    toggled  = '0;
    prev_clk = dom_clk;
    repeat (4 * MAX_HALF + 8) begin
      @(negedge clk);
      toggled  = toggled | (dom_clk ^ prev_clk);
      prev_clk = dom_clk;
    end
    check_dom("dom_clk_o toggles", toggled, 3'b101);
    check_dom("dom_clk_o[1] level", dom_clk & 3'b010, '0);
    checked_access(1'b1, 3'd3, 1'b1, 16'h0000);
    measure_period(1, cycles);
    check_period("dom_clk_o[1] period", div_m[1], cycles);

    // Debug reset leaves the global reset alone
    @(negedge clk);
    dbg_rst = 1'b1;
    #1;
    check_dom("dom_rstn_o", dom_rstn, '0);
    check_dom("glob_rstn_o", dom_vec_t'(glob_rstn), 3'b001);
    repeat (5) @(negedge clk);
    dbg_rst = 1'b0;
    fork
      release_check(0, 1'b0);
      release_check(1, 1'b0);
      release_check(2, 1'b0);
    join
    check_dom("glob_rstn_o", dom_vec_t'(glob_rstn), 3'b001);

    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/clkgen_pkg.sv
design/cfg_arbiter.sv
design/clk_cfg_regs.sv
design/clk_domain_gen.sv
design/clkgen_top.sv
bench/clkgen_sva.sv
bench/clkgen_tb.sv

//--- Makefile
# Verilator simulation of the clock generator

VERILATOR ?= verilator
TOP       ?= clkgen_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
